// File: bench/tb_wb_interconnect.sv
module tb_wb_interconnect
	import bus_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////////////////////////////////////////
	// Constants and types
	////////////////////////////////////////////////////////////////////////////

	// Eight hex words per golden line
	localparam int FIELDS     = 8;
	localparam int MAX_OPS    = 64;
	// Longest any single wait may last, in cycles
	localparam int WAIT_LIMIT = 100;

	// Operation codes in the golden file
	localparam logic [31:0] OP_READ  = 32'h0;
	localparam logic [31:0] OP_WRITE = 32'h1;
	localparam logic [31:0] OP_DROP  = 32'hD;
	// Response kinds in the golden file
	localparam logic [31:0] KIND_NONE = 32'h0;
	localparam logic [31:0] KIND_ERR  = 32'hE;

	// One response still owed to the master
	typedef struct packed {
		logic [7:0] test;
		logic       is_err;
		logic       check_data;
		wb_data_t   data;
	} expect_t;

	// One operation from the golden table
	typedef struct packed {
		logic [31:0] test;
		logic [31:0] op;
		wb_addr_t    addr;
		wb_data_t    wdata;
		wb_sel_t     sel;
		logic [31:0] kind;
		wb_data_t    rdata;
		// No idle gap before this one
		logic        b2b;
	} golden_op_t;

	logic        i_clk;
	logic        i_reset;
	logic        wb_cyc;
	logic        wb_stb;
	wb_req_t     wb_req;
	logic        wb_stall;
	wb_rsp_t     wb_rsp;

	logic [31:0] golden [FIELDS*MAX_OPS];
	// Expected responses in request order
	expect_t     exp_q [$];
	int          cur_test;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;
	bit          timed_out;

	wb_interconnect_top i_wb_interconnect_top (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_req   (wb_req),
		.o_wb_stall (wb_stall),
		.o_wb_rsp   (wb_rsp)
	);

	// 10 ns clock
	initial
	begin
		i_clk = 1'b0;
		forever
			#5 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Driver helpers
	////////////////////////////////////////////////////////////////////////////

	// Unpack one golden line from the flat word array
	function automatic golden_op_t fetch_op(input int n);
		golden_op_t g;
		g.test  = golden[n*FIELDS];
		g.op    = golden[n*FIELDS+1];
		g.addr  = golden[n*FIELDS+2];
		g.wdata = golden[n*FIELDS+3];
		g.sel   = wb_sel_t'(golden[n*FIELDS+4]);
		g.kind  = golden[n*FIELDS+5];
		g.rdata = golden[n*FIELDS+6];
		g.b2b   = golden[n*FIELDS+7][0];
		return g;
	endfunction

	task automatic idle_cycle();
		@(posedge i_clk);
		wb_stb <= 1'b0;
	endtask

	// Stall sampled at the falling edge decides the next rising edge
	task automatic wait_accept(output bit ok);
		int n;
		n = 0;
		@(negedge i_clk);
		while (wb_stall && (n < WAIT_LIMIT))
		begin
			@(negedge i_clk);
			n++;
		end
		ok = !wb_stall;
	endtask

	task automatic wait_drain(output bit ok);
		int n;
		n = 0;
		while ((exp_q.size() != 0) && (n < WAIT_LIMIT))
		begin
			@(negedge i_clk);
			n++;
		end
		ok = (exp_q.size() == 0);
	endtask

	task automatic issue_op(input golden_op_t g);
		expect_t e;
		wb_req_t r;
		bit      ok;
		int      gap;
		gap = g.b2b ? 0 : $urandom % 3;
		repeat (gap)
			idle_cycle();
		if (g.op == OP_DROP)
		begin
			// Abandon the cycle for two clocks
			@(posedge i_clk);
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			repeat (2)
				@(posedge i_clk);
			wb_cyc <= 1'b1;
		end
		else if ((g.op != OP_READ) && (g.op != OP_WRITE))
		begin
			$display("Test %0d has an unknown operation code %h", cur_test, g.op);
			test_errors++;
			total_errors++;
		end
		else
		begin
			r.we   = (g.op == OP_WRITE);
			r.addr = g.addr;
			r.data = g.wdata;
			r.sel  = g.sel;
			@(posedge i_clk);
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
			wb_req <= r;
			// Held unchanged while stalled
			wait_accept(ok);
			if (!ok)
			begin
				$display("Test %0d timed out with the request stalled", cur_test);
				timed_out = 1'b1;
			end
			else if (g.kind != KIND_NONE)
			begin
				e.test       = g.test[7:0];
				e.is_err     = (g.kind == KIND_ERR);
				e.check_data = !r.we && (g.kind != KIND_ERR);
				e.data       = g.rdata;
				exp_q.push_back(e);
			end
		end
	endtask

	// Drain the test, then report it
	task automatic finish_test();
		bit ok;
		if (!timed_out)
		begin
			idle_cycle();
			wait_drain(ok);
			if (!ok)
			begin
				$display("Test %0d timed out with %0d responses missing",
					cur_test, exp_q.size());
				timed_out = 1'b1;
			end
			// Quiet cycles so stray responses land in this test
			repeat (4)
				@(negedge i_clk);
		end
		tests_run++;
		if ((test_errors == 0) && !timed_out)
			$display("test %0d: ok", cur_test);
		else
		begin
			tests_failed++;
			$display("test %0d: FAILED with %0d errors", cur_test, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Response monitor
	////////////////////////////////////////////////////////////////////////////

	task automatic check_response();
		expect_t e;
		if (exp_q.size() == 0)
		begin
			$display("Test %0d saw a response with no request outstanding", cur_test);
			test_errors++;
			total_errors++;
		end
		else
		begin
			e = exp_q.pop_front();
			if (wb_rsp.err != e.is_err)
			begin
				$display("CHECK FAILED wb_rsp.err: got %h, expected %h (test %0d)",
					wb_rsp.err, e.is_err, e.test);
				test_errors++;
				total_errors++;
			end
			if (wb_rsp.ack != !e.is_err)
			begin
				$display("CHECK FAILED wb_rsp.ack: got %h, expected %h (test %0d)",
					wb_rsp.ack, !e.is_err, e.test);
				test_errors++;
				total_errors++;
			end
			// Read data only matters on a read ack
			if (e.check_data && wb_rsp.ack && (wb_rsp.data != e.data))
			begin
				$display("CHECK FAILED wb_rsp.data: got %h, expected %h (test %0d)",
					wb_rsp.data, e.data, e.test);
				test_errors++;
				total_errors++;
			end
		end
	endtask

	always @(negedge i_clk)
	begin
		if (!i_reset && (wb_rsp.ack || wb_rsp.err))
			check_response();
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : main_seq
		golden_op_t g;
		void'($urandom(32'hcedc_a34b));
		i_reset      = 1'b1;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_req       = '0;
		timed_out    = 1'b0;
		test_errors  = 0;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		$readmemh("bench/wb_golden.txt", golden);
		repeat (8)
			@(posedge i_clk);
		i_reset <= 1'b0;

		// Test 1 checks idle outputs after reset
		cur_test = 1;
		repeat (2)
			@(negedge i_clk);
		if (wb_stall !== 1'b0)
		begin
			$display("CHECK FAILED wb_stall: got %h, expected 0 (test 1)", wb_stall);
			test_errors++;
			total_errors++;
		end
		if ((wb_rsp.ack !== 1'b0) || (wb_rsp.err !== 1'b0))
		begin
			$display("CHECK FAILED wb_rsp.ack/err: got %h/%h, expected 0/0 (test 1)",
				wb_rsp.ack, wb_rsp.err);
			test_errors++;
			total_errors++;
		end

		// Test number 0 ends the table
		for (int n = 0; n < MAX_OPS; n++)
		begin
			g = fetch_op(n);
			if (timed_out || $isunknown(g.test) || (g.test == '0))
				break;
			if (int'(g.test) != cur_test)
			begin
				finish_test();
				cur_test = int'(g.test);
			end
			issue_op(g);
		end
		finish_test();

		$display("Summary: %0d tests run, %0d passed, %0d failed, %0d check errors",
			tests_run, tests_run - tests_failed, tests_failed, total_errors);
		if ((tests_failed == 0) && (total_errors == 0) && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: bench/wb_golden.txt
// Columns, all hex: test op addr wdata sel kind rdata b2b
// op 0 read, 1 write, D drop cyc; kind A ack, E err, 0 none; b2b 1 means no idle gap

// Test 2: same offset in every region, then write and read back to back
02 1 00000044 11110044 F A 00000000 0
02 1 00001044 22221044 F A 00000000 0
02 1 00002044 33332044 F A 00000000 0
02 1 80000044 44448044 F A 00000000 0
02 0 00000044 00000000 F A 11110044 0
02 0 00001044 00000000 F A 22221044 0
02 0 00002044 00000000 F A 33332044 0
02 0 80000044 00000000 F A 44448044 0
02 1 00000010 0A0B0C0D F A 00000000 0
02 0 00000010 00000000 F A 0A0B0C0D 1
02 1 00002010 5A5A2010 F A 00000000 0
02 0 00002010 00000000 F A 5A5A2010 1

// Test 3: byte lanes, new byte where sel is set, old byte elsewhere
03 1 00001080 AABBCCDD F A 00000000 0
03 1 00001080 11223344 5 A 00000000 0
03 0 00001080 00000000 F A AA22CC44 0
03 0 00001C80 00000000 F A AA22CC44 0
03 1 00002084 01234567 F A 00000000 0
03 1 00002084 89ABCDEF A A 00000000 1
03 0 00002084 00000000 F A 8923CD67 1
03 1 80000088 DEADBEEF F A 00000000 0
03 1 80000088 55000000 8 A 00000000 0
03 0 80000088 00000000 F A 55ADBEEF 0

// Test 4: unmapped addresses answer err, mapped words stay intact
04 1 40000044 BAD0BAD0 F E 00000000 0
04 0 40000044 00000000 F E 00000000 0
04 0 00000044 00000000 F A 11110044 0
04 1 00003044 BAD1BAD1 F E 00000000 0
04 0 00002044 00000000 F A 33332044 1
04 0 FFFFF044 00000000 F E 00000000 0
04 0 80000044 00000000 F A 44448044 1

// Test 5: pipelined reads bouncing between slave 2 and slave 0
05 1 00000048 5A5A0048 F A 00000000 0
05 1 00002048 A5A52048 F A 00000000 0
05 0 00002044 00000000 F A 33332044 0
05 0 00000044 00000000 F A 11110044 1
05 0 00002048 00000000 F A A5A52048 1
05 0 00000048 00000000 F A 5A5A0048 1
05 0 00002084 00000000 F A 8923CD67 1
05 0 00002010 00000000 F A 5A5A2010 1
05 0 00000010 00000000 F A 0A0B0C0D 1
05 0 00002044 00000000 F A 33332044 1

// Test 6: drop cyc with slave 2 reads in flight, then carry on
06 0 00002044 00000000 F 0 00000000 0
06 0 00002048 00000000 F 0 00000000 1
06 0 00002084 00000000 F 0 00000000 1
06 D 00000000 00000000 0 0 00000000 1
06 0 00002048 00000000 F A A5A52048 1
06 1 00002040 600DD00D F A 00000000 0
06 0 00002040 00000000 F A 600DD00D 0
06 0 00000044 00000000 F A 11110044 1

// End of table
00 0 00000000 00000000 0 0 00000000 0

// File: design/addr_decode.sv
module addr_decode
	import bus_types_pkg::*;
	import slave_map_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	// Upstream side, from the master
	input  logic       i_valid,
	output logic       o_stall,
	input  wb_req_t    i_req,
	// Downstream side, toward the router
	output logic       o_valid,
	input  logic       i_stall,
	output slave_sel_t o_decode,
	output wb_req_t    o_req
);

	// Combinational one-hot select for the incoming address
	slave_sel_t request;
	// Some slave claims the address
	logic       any_hit;

	////////////////////////////////////////////////////////////////////////////
	// Address match against the slave map
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		any_hit = 1'b0;
		for (int k = 0; k < NUM_SLAVES; k++)
		begin
			// Masked address bits must equal the base
			request[k] = i_valid && ((i_req.addr & SLAVE_MASK[k]) == SLAVE_BASE[k]);
			any_hit = any_hit | request[k];
		end
		// Nobody owns it, so the router answers with err
		request[NUM_SLAVES] = i_valid && !any_hit;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register stage
	////////////////////////////////////////////////////////////////////////////

	// Hold off the master only while a stalled word sits in the register
	assign o_stall = o_valid && i_stall;

	// Control half, cleared by reset
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid  <= 1'b0;
			o_decode <= '0;
		end
		else if (!o_stall)
		begin
			o_valid  <= i_valid;
			// Zero when no request comes in
			o_decode <= request;
		end
	end

	// Payload half, loads on the same condition
	always_ff @(posedge i_clk)
	begin
		if (!o_stall)
			o_req <= i_req;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Valid output always carries exactly one select bit
	a_valid_decode: assert property (@(posedge i_clk) disable iff (i_reset)
		o_valid == (o_decode != '0));

	a_decode_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0(o_decode));

	// Router sees a frozen word until it takes it
	a_hold_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_valid && i_stall) |=> (o_valid && $stable(o_decode) && $stable(o_req)));

endmodule

// File: design/bus_types_pkg.sv
package bus_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone bus widths
	////////////////////////////////////////////////////////////////////////////

	// Byte addressed, 32-bit words
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// One select bit per byte lane
	localparam int SEL_W = DATA_W / 8;
	localparam int BYTE_W = DATA_W / SEL_W;
	// Lowest address bit that picks a word
	localparam int WORD_LSB = $clog2(SEL_W);

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [SEL_W-1:0]  wb_sel_t;

	////////////////////////////////////////////////////////////////////////////
	// Request and response payloads
	////////////////////////////////////////////////////////////////////////////

	// Request fields that ride alongside cyc and stb
	typedef struct packed {
		// High for a write
		logic     we;
		wb_addr_t addr;
		// Write data, ignored on reads
		wb_data_t data;
		wb_sel_t  sel;
	} wb_req_t;

	// One response cycle has ack or err set, never both
	typedef struct packed {
		logic     ack;
		logic     err;
		// Read data, only meaningful with ack
		wb_data_t data;
	} wb_rsp_t;

endpackage

// File: design/ram_slave.sv
module ram_slave
	import bus_types_pkg::*;
	import slave_map_pkg::*;
#(
	parameter int LATENCY = DEFAULT_LATENCY,
	parameter int DEPTH   = RAM_DEPTH
)
(
	input  logic    i_clk,
	input  logic    i_reset,
	input  logic    i_stb,
	input  wb_req_t i_req,
	output wb_rsp_t o_rsp
);

	// Word index into the array
	typedef logic [$clog2(DEPTH)-1:0] ram_idx_t;

	wb_data_t           mem [DEPTH];
	ram_idx_t           idx;
	// Ack and data travel side by side
	logic [LATENCY-1:0] ack_pipe;
	wb_data_t           data_pipe [LATENCY];

	// Upper region bits alias
	assign idx = i_req.addr[WORD_LSB +: $clog2(DEPTH)];

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			// Old word, even when written this cycle
			data_pipe[0] <= mem[idx];
			if (i_req.we)
			begin
				// Only lanes with their select bit set
				for (int b = 0; b < SEL_W; b++)
					if (i_req.sel[b])
						mem[idx][b*BYTE_W +: BYTE_W] <= i_req.data[b*BYTE_W +: BYTE_W];
			end
		end
		// Read data follows its ack down the pipe
		for (int k = 1; k < LATENCY; k++)
			data_pipe[k] <= data_pipe[k-1];
	end

	////////////////////////////////////////////////////////////////////////////
	// Acknowledge pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ack_pipe <= '0;
		else
		begin
			ack_pipe[0] <= i_stb;
			for (int k = 1; k < LATENCY; k++)
				ack_pipe[k] <= ack_pipe[k-1];
		end
	end

	assign o_rsp.ack  = ack_pipe[LATENCY-1];
	// No failure path in a RAM
	assign o_rsp.err  = 1'b0;
	assign o_rsp.data = data_pipe[LATENCY-1];

	// Fixed latency, one ack per strobe and none otherwise
	a_fixed_latency: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rsp.ack == $past(i_stb, LATENCY));

endmodule

// File: design/slave_map_pkg.sv
package slave_map_pkg;
	import bus_types_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Slave population and decode vectors
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_SLAVES = 4;
	// Slave index also covers the error responder
	localparam int SLAVE_IDX_W = $clog2(NUM_SLAVES + 1);
	// Room for more responses in flight than the slowest slave allows
	localparam int OUTST_W = 4;

	// One bit per slave, top bit flags an unowned address
	typedef logic [NUM_SLAVES:0]    slave_sel_t;
	typedef logic [SLAVE_IDX_W-1:0] slave_idx_t;
	typedef logic [OUTST_W-1:0]     outstanding_t;

	// Index used for the internal error responder
	localparam slave_idx_t ERR_TARGET = slave_idx_t'(NUM_SLAVES);

	////////////////////////////////////////////////////////////////////////////
	// Address map and slave timing
	////////////////////////////////////////////////////////////////////////////

	// Each slave owns one 4 KB region
	localparam wb_addr_t SLAVE_BASE [NUM_SLAVES] = '{
		32'h0000_0000, 32'h0000_1000, 32'h0000_2000, 32'h8000_0000
	};
	localparam wb_addr_t SLAVE_MASK [NUM_SLAVES] = '{default: 32'hFFFF_F000};

	localparam int DEFAULT_LATENCY = 1;
	// Slave 2 is the slow one
	localparam int SLAVE_LATENCY [NUM_SLAVES] = '{
		DEFAULT_LATENCY, DEFAULT_LATENCY, 3, DEFAULT_LATENCY
	};
	// 256 words, indexed by address bits 9:2
	localparam int RAM_DEPTH = 256;

endpackage

// File: design/slave_router.sv
module slave_router
	import bus_types_pkg::*;
	import slave_map_pkg::*;
(
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  logic                       i_cyc,
	// Decoded request from the decoder stage
	input  logic                       i_valid,
	input  slave_sel_t                 i_decode,
	input  wb_req_t                    i_req,
	output logic                       o_dec_stall,
	// Slave side
	output logic [NUM_SLAVES-1:0]      o_slave_stb,
	output wb_req_t                    o_slave_req,
	input  wb_rsp_t [NUM_SLAVES-1:0]   i_slave_rsp,
	// Response back to the master
	output wb_rsp_t                    o_rsp
);

	// Slave that owns the responses now in flight
	slave_idx_t   cur_idx;
	// Index of the decoded request
	slave_idx_t   target;
	// Responses owed to the master in this cycle
	outstanding_t outstanding;
	// Stale acks still due after cyc was dropped
	outstanding_t drain;
	logic         err_pending;
	logic         cur_is_slave;
	wb_rsp_t      rsp_sel;
	logic         rsp_hit;
	logic         take;
	logic         resp_done;

	////////////////////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////////////////////

	// One-hot select to index, err target when no slave bit is set
	always_comb
	begin
		target = ERR_TARGET;
		for (int k = 0; k < NUM_SLAVES; k++)
			if (i_decode[k])
				target = slave_idx_t'(k);
	end

	// Switching slaves waits for the old one to finish
	// Also hold new work until stale acks have drained
	assign o_dec_stall = i_cyc && i_valid
		&& ((drain != '0) || ((target != cur_idx) && (outstanding != '0)));

	// A request outside a cycle is simply dropped
	assign take = i_cyc && i_valid && !o_dec_stall;

	assign o_slave_stb = take ? i_decode[NUM_SLAVES-1:0] : '0;
	assign o_slave_req = i_req;

	////////////////////////////////////////////////////////////////////////////
	// Response side
	////////////////////////////////////////////////////////////////////////////

	assign cur_is_slave = (cur_idx != ERR_TARGET);

	// Only the current slave may answer
	always_comb
	begin
		rsp_sel = '0;
		for (int k = 0; k < NUM_SLAVES; k++)
			if (cur_idx == slave_idx_t'(k))
				rsp_sel = i_slave_rsp[k];
	end

	assign rsp_hit = rsp_sel.ack;

	// Stale acks never count against live requests
	assign resp_done = i_cyc && (drain == '0) && (rsp_hit || err_pending);

	assign o_rsp.ack  = i_cyc && (drain == '0) && rsp_hit;
	assign o_rsp.err  = i_cyc && err_pending;
	assign o_rsp.data = rsp_sel.data;

	////////////////////////////////////////////////////////////////////////////
	// Tracking state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			cur_idx     <= '0;
			outstanding <= '0;
			drain       <= '0;
			err_pending <= 1'b0;
		end
		else if (!i_cyc)
		begin
			// Abandon the cycle
			outstanding <= '0;
			err_pending <= 1'b0;
			// Slave acks still in flight must be swallowed later
			drain <= drain + (cur_is_slave ? outstanding : '0) - outstanding_t'(rsp_hit);
		end
		else
		begin
			if (take)
				cur_idx <= target;
			outstanding <= outstanding + outstanding_t'(take) - outstanding_t'(resp_done);
			// Error answer one cycle after the unmapped request
			err_pending <= take && (target == ERR_TARGET);
			if ((drain != '0) && rsp_hit)
				drain <= drain - 1'b1;
		end
	end

	// Every response pairs with an earlier request
	a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset)
		resp_done |-> (outstanding != '0));

	// Slave ack and internal err never collide
	a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_rsp.ack && o_rsp.err));

endmodule

// File: design/wb_interconnect_top.sv
module wb_interconnect_top
	import bus_types_pkg::*;
	import slave_map_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_reset,
	// Master port
	input  logic    i_wb_cyc,
	input  logic    i_wb_stb,
	input  wb_req_t i_wb_req,
	output logic    o_wb_stall,
	output wb_rsp_t o_wb_rsp
);

	// Master request qualifier
	logic                     req_valid;
	// Decoder to router
	logic                     dec_valid;
	logic                     dec_stall;
	slave_sel_t               dec_decode;
	wb_req_t                  dec_req;
	// Router to slaves
	logic [NUM_SLAVES-1:0]    slave_stb;
	wb_req_t                  slave_req;
	wb_rsp_t [NUM_SLAVES-1:0] slave_rsp;

	assign req_valid = i_wb_cyc && i_wb_stb;

	////////////////////////////////////////////////////////////////////////////
	// Request path
	////////////////////////////////////////////////////////////////////////////

	// Registered decode stage, its stall goes straight to the master
	addr_decode u_decode (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_valid  (req_valid),
		.o_stall  (o_wb_stall),
		.i_req    (i_wb_req),
		.o_valid  (dec_valid),
		.i_stall  (dec_stall),
		.o_decode (dec_decode),
		.o_req    (dec_req)
	);

	slave_router u_router (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cyc       (i_wb_cyc),
		.i_valid     (dec_valid),
		.i_decode    (dec_decode),
		.i_req       (dec_req),
		.o_dec_stall (dec_stall),
		.o_slave_stb (slave_stb),
		.o_slave_req (slave_req),
		.i_slave_rsp (slave_rsp),
		.o_rsp       (o_wb_rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// Slaves
	////////////////////////////////////////////////////////////////////////////

	// Same RAM everywhere, latency from the slave table
	for (genvar k = 0; k < NUM_SLAVES; k++)
	begin : g_slave
		ram_slave #(
			.LATENCY (SLAVE_LATENCY[k]),
			.DEPTH   (RAM_DEPTH)
		) u_ram (
			.i_clk   (i_clk),
			.i_reset (i_reset),
			.i_stb   (slave_stb[k]),
			.i_req   (slave_req),
			.o_rsp   (slave_rsp[k])
		);
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run from the project root, then look for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_interconnect \
	-f src.f -Mdir obj_dir -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "Build or simulation did not complete"
grep -qx "Regression passed" sim.log && echo "PASS" && exit 0 \
	|| { echo "FAIL, see sim.log"; exit 1; }

// File: src.f
design/bus_types_pkg.sv
design/slave_map_pkg.sv
design/addr_decode.sv
design/slave_router.sv
design/ram_slave.sv
design/wb_interconnect_top.sv
bench/tb_wb_interconnect.sv
